// File: flist.f
source/ru_pkg.sv
source/ru_fifo_ctrl.sv
source/ru_fifo_ram.sv
source/ru_page_writer.sv
source/ru_write_channel.sv
verification/ru_write_channel_sva.sv
verification/tb_clk_gen.sv
verification/tb_checker.sv
verification/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the write channel testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f flist.f -o sim_tb \
    || { echo "build failed"; exit 1; }

out="$(./obj_dir/sim_tb 2>&1)" || true
printf '%s\n' "$out"

grep -qx '>>> PASS' <<< "$out" && echo "result: pass" || { echo "result: fail"; exit 1; }

// File: source/ru_fifo_ctrl.sv
`timescale 1ns/1ps

module ru_fifo_ctrl
    import ru_pkg::*;
(
    input  logic                   rclk,
    input  logic                   rrst,
    input  logic                   push,      // write request from host
    input  logic                   pop,       // read request from page writer
    output logic                   wr_ok,     // accepted write, gates the ram
    output logic [DEPTH_WIDTH-1:0] waddr,
    output logic [DEPTH_WIDTH-1:0] raddr,
    output fifo_status_t           status
);

    //************************************************************
    // pointers
    //************************************************************
    // binary pointers, msb is the lap bit
    logic [LEVEL_WIDTH-1:0] wptr;
    logic [LEVEL_WIDTH-1:0] rptr;
    logic [LEVEL_WIDTH-1:0] wptr_next;
    logic [LEVEL_WIDTH-1:0] rptr_next;

    logic rd_ok;                              // pop that is honoured

    // registered flags
    logic                   full_q;
    logic                   empty_q;
    logic [LEVEL_WIDTH-1:0] level_q;

    // next-state flag terms
    logic                   full_next;
    logic                   empty_next;
    logic [LEVEL_WIDTH-1:0] level_next;
    logic [DEPTH_WIDTH-1:0] low_diff;         // address-only distance
    logic                   same_lap;

    assign wr_ok = push & ~full_q;            // drop pushes while full
    assign rd_ok = pop & ~empty_q;            // ignore pops while empty

    always_comb
    begin
        wptr_next = wptr + LEVEL_WIDTH'(wr_ok);
        rptr_next = rptr + LEVEL_WIDTH'(rd_ok);
    end

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            wptr <= '0;
            rptr <= '0;
        end
        else
        begin
            wptr <= wptr_next;
            rptr <= rptr_next;
        end
    end

    // ram addresses are the pointers without the lap bit
    assign waddr = wptr[DEPTH_WIDTH-1:0];
    assign raddr = rptr[DEPTH_WIDTH-1:0];

    //************************************************************
    // full / empty / level from the next pointers
    //************************************************************
    assign same_lap = (wptr_next[DEPTH_WIDTH] == rptr_next[DEPTH_WIDTH]);
    assign low_diff = wptr_next[DEPTH_WIDTH-1:0] - rptr_next[DEPTH_WIDTH-1:0];

    always_comb
    begin
        // full when a lap apart on the same address
        full_next  = !same_lap && (low_diff == '0);
        empty_next = (wptr_next == rptr_next);

        if (same_lap)
            level_next = {1'b0, low_diff};                   // writer ahead on this lap
        else
            level_next = {1'b1, wptr_next[DEPTH_WIDTH-1:0]}  // writer has wrapped
                       - {1'b0, rptr_next[DEPTH_WIDTH-1:0]};
    end

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            full_q  <= 1'b0;
            empty_q <= 1'b1;                  // nothing stored yet
            level_q <= '0;
        end
        else
        begin
            full_q  <= full_next;
            empty_q <= empty_next;
            level_q <= level_next;
        end
    end

    //************************************************************
    // status out
    //************************************************************
    always_comb
    begin
        status.full         = full_q;
        status.empty        = empty_q;
        status.level        = level_q;
        // almost flags follow the registered level
        status.almost_full  = (level_q >= LEVEL_WIDTH'(ALMOST_FULL_NUM));
        status.almost_empty = (level_q <= LEVEL_WIDTH'(ALMOST_EMPTY_NUM));
    end

endmodule

// File: source/ru_fifo_ram.sv
`timescale 1ns/1ps

module ru_fifo_ram
    import ru_pkg::*;
(
    input  logic                   rclk,
    input  logic                   we,        // accepted push only
    input  logic [DEPTH_WIDTH-1:0] waddr,
    input  logic [DATA_WIDTH-1:0]  wdata,
    input  logic [DEPTH_WIDTH-1:0] raddr,
    output logic [DATA_WIDTH-1:0]  rd_data    // head byte, same cycle
);

    // distributed style storage
    logic [DATA_WIDTH-1:0] mem [0:FIFO_DEPTH-1];

    //************************************************************
    // write port
    //************************************************************
    always_ff @(posedge rclk)
    begin
        if (we)
            mem[waddr] <= wdata;              // lands on the push edge
    end

    //************************************************************
    // read port
    //************************************************************
    // asynchronous read, head byte visible while popping
    assign rd_data = mem[raddr];

endmodule

// File: source/ru_page_writer.sv
`timescale 1ns/1ps

module ru_page_writer
    import ru_pkg::*;
(
    input  logic                  rclk,
    input  logic                  rrst,
    input  fifo_status_t          status,
    input  logic [DATA_WIDTH-1:0] rd_data,     // fifo head
    input  logic                  flash_busy,  // programmer back-pressure
    output logic                  pop,
    output flash_byte_t           flash_out
);

    writer_state_t state;
    writer_state_t state_next;

    logic [PAGE_CNT_WIDTH-1:0] byte_cnt;       // data bytes sent in this burst
    logic [DATA_WIDTH-1:0]     page_idx;       // wraps at 256

    logic page_ready;                          // start condition
    logic last_byte;                           // fourth data byte

    // output registers
    logic                  out_stb;
    logic                  out_last;
    logic [DATA_WIDTH-1:0] out_data;

    assign page_ready = (status.level >= LEVEL_WIDTH'(PAGE_BYTES)) && !flash_busy;
    assign last_byte  = (byte_cnt == PAGE_CNT_WIDTH'(PAGE_BYTES - 1));

    // one pop per data cycle
    assign pop = (state == ST_DATA);

    //************************************************************
    // fsm
    //************************************************************
    always_comb
    begin
        state_next = state;
        unique case (state)
            ST_IDLE:   if (page_ready) state_next = ST_OPCODE;  // busy only looked at here
            ST_OPCODE: state_next = ST_INDEX;
            ST_INDEX:  state_next = ST_DATA;
            ST_DATA:   if (last_byte) state_next = ST_IDLE;
            default:   state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            state    <= ST_IDLE;
            byte_cnt <= '0;
            page_idx <= '0;
        end
        else
        begin
            state <= state_next;
            if (state == ST_INDEX)
                byte_cnt <= '0;                        // fresh count per page
            else if (state == ST_DATA)
            begin
                byte_cnt <= byte_cnt + 1'b1;
                if (last_byte)
                    page_idx <= page_idx + 1'b1;       // next page after the last byte
            end
        end
    end

    //************************************************************
    // flash byte stream, one cycle behind the state
    //************************************************************
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            out_stb  <= 1'b0;
            out_last <= 1'b0;
        end
        else
        begin
            out_stb  <= (state != ST_IDLE);            // 6 strobes per burst
            out_last <= (state == ST_DATA) && last_byte;
        end
    end

    always_ff @(posedge rclk)
    begin
        case (state)
            ST_OPCODE: out_data <= OP_PAGE_PROGRAM;
            ST_INDEX:  out_data <= page_idx;
            ST_DATA:   out_data <= rd_data;            // byte being popped
            default:   out_data <= out_data;           // hold between bursts
        endcase
    end

    always_comb
    begin
        flash_out.stb  = out_stb;
        flash_out.data = out_data;
        flash_out.last = out_last;
    end

endmodule

// File: source/ru_pkg.sv
package ru_pkg;

    //************************************************************
    // fifo geometry
    //************************************************************
    localparam int DEPTH_WIDTH = 4;                    // address bits, 16 entries
    localparam int FIFO_DEPTH  = 1 << DEPTH_WIDTH;     // storage entries
    localparam int LEVEL_WIDTH = DEPTH_WIDTH + 1;      // room for a full count of 16
    localparam int DATA_WIDTH  = 8;                    // one config byte

    // water marks
    localparam int ALMOST_FULL_NUM  = 12;              // almost_full at level >= this
    localparam int ALMOST_EMPTY_NUM = 2;               // almost_empty at level <= this

    //************************************************************
    // flash page burst
    //************************************************************
    localparam int PAGE_BYTES     = 4;                 // data bytes per page
    localparam int PAGE_CNT_WIDTH = $clog2(PAGE_BYTES);

    // first byte of every burst
    typedef enum logic [DATA_WIDTH-1:0] {
        OP_PAGE_PROGRAM = 8'h02
    } flash_op_t;

    // page writer fsm
    typedef enum logic [1:0] {
        ST_IDLE,        // waiting for a whole page and an idle programmer
        ST_OPCODE,      // opcode byte goes out next
        ST_INDEX,       // page index byte goes out next
        ST_DATA         // four popped data bytes
    } writer_state_t;

    // fifo flags plus occupancy
    typedef struct packed {
        logic                   full;
        logic                   almost_full;
        logic                   empty;
        logic                   almost_empty;
        logic [LEVEL_WIDTH-1:0] level;
    } fifo_status_t;

    // one byte toward the flash programmer
    typedef struct packed {
        logic                  stb;     // byte valid this cycle
        logic [DATA_WIDTH-1:0] data;
        logic                  last;    // final byte of the burst
    } flash_byte_t;

endpackage

// File: source/ru_write_channel.sv
`timescale 1ns/1ps

module ru_write_channel
    import ru_pkg::*;
(
    input  logic                  rclk,
    input  logic                  rrst,
    input  logic                  in_stb,      // host push strobe
    input  logic [DATA_WIDTH-1:0] in_data,
    input  logic                  flash_busy,
    output fifo_status_t          status,
    output flash_byte_t           flash_out
);

    //************************************************************
    // internal nets
    //************************************************************
    logic                   wr_ok;             // push that was taken
    logic [DEPTH_WIDTH-1:0] waddr;
    logic [DEPTH_WIDTH-1:0] raddr;
    logic [DATA_WIDTH-1:0]  rd_data;           // fifo head byte
    logic                   pop;

    // pointers and flags
    ru_fifo_ctrl u_fifo_ctrl (
        .rclk   (rclk),
        .rrst   (rrst),
        .push   (in_stb),
        .pop    (pop),
        .wr_ok  (wr_ok),
        .waddr  (waddr),
        .raddr  (raddr),
        .status (status)
    );

    // byte storage
    ru_fifo_ram u_fifo_ram (
        .rclk    (rclk),
        .we      (wr_ok),                      // only accepted pushes write
        .waddr   (waddr),
        .wdata   (in_data),
        .raddr   (raddr),
        .rd_data (rd_data)
    );

    // drains whole pages into bursts
    ru_page_writer u_page_writer (
        .rclk       (rclk),
        .rrst       (rrst),
        .status     (status),
        .rd_data    (rd_data),
        .flash_busy (flash_busy),
        .pop        (pop),
        .flash_out  (flash_out)
    );

endmodule

// File: verification/ru_write_channel_sva.sv
`timescale 1ns/1ps

module ru_write_channel_sva
    import ru_pkg::*;
(
    input logic          rclk,
    input logic          rrst,
    input fifo_status_t  status,
    input flash_byte_t   flash_out,
    input logic          pop,
    input writer_state_t state
);

    // flags exclusive
    a_full_empty: assert property (@(posedge rclk) disable iff (rrst)
        !(status.full && status.empty))
        else $error("status.full and status.empty high together");

    // no gap inside a burst
    a_burst_run: assert property (@(posedge rclk) disable iff (rrst)
        (flash_out.stb && !flash_out.last) |=> flash_out.stb)
        else $error("flash_out.stb dropped before last");

    a_idle_pop: assert property (@(posedge rclk) disable iff (rrst)
        (state == ST_IDLE) |-> !pop)
        else $error("pop high while the writer is idle");

endmodule

// fsm state comes from the page writer below the top
bind ru_write_channel ru_write_channel_sva u_sva (
    .rclk      (rclk),
    .rrst      (rrst),
    .status    (status),
    .flash_out (flash_out),
    .pop       (pop),
    .state     (u_page_writer.state)
);

// File: verification/tb_checker.sv
`timescale 1ns/1ps

module tb_checker
    import ru_pkg::*;
(
    input  logic                  rclk,
    input  logic                  rrst,
    input  int                    phase,       // test number from tb_top
    input  logic                  in_stb,
    input  logic [DATA_WIDTH-1:0] in_data,
    input  logic                  flash_busy,
    input  fifo_status_t          status,
    input  flash_byte_t           flash_out,
    output int                    check_cnt,
    output int                    err_cnt,
    output int                    test_cnt
);

    //************************************************************
    // model state
    //************************************************************
    logic [DATA_WIDTH-1:0] model_q [$];        // accepted bytes not yet sent
    int                    burst_pos = 0;      // 0 opcode, 1 index, 2..5 data
    int                    page_exp  = 0;      // next page index
    logic                  busy_d1   = 1'b0;   // busy one edge back
    logic                  busy_d2   = 1'b0;   // and two edges back
    int                    cur_phase = 0;
    int                    n_checks  = 0;
    int                    n_errors  = 0;
    int                    n_tests   = 0;
    int                    test_chk  = 0;
    int                    test_err  = 0;

    assign check_cnt = n_checks;
    assign err_cnt   = n_errors;
    assign test_cnt  = n_tests;

    function automatic string test_name(input int p);
        case (p)
            0:       return "reset";
            1:       return "random_push";
            2:       return "back_pressure";
            3:       return "drain";
            default: return "idle";
        endcase
    endfunction

    task automatic compare(input string name, input int exp, input int act);
        n_checks++;
        test_chk++;
        if (exp != act)
        begin
            $display("Fail %0t ns %s expected %0h actual %0h", $time, name, exp, act);
            n_errors++;
            test_err++;
        end
    endtask

    task automatic complain(input string what);
        $display("Error at %0t ns: %s", $time, what);
        n_errors++;
        test_err++;
    endtask

    // one line per finished test
    task automatic finish_test();
        if (test_err == 0)
            $display("test %s: ok, %0d checks", test_name(cur_phase), test_chk);
        else
            $display("test %s: %0d errors in %0d checks", test_name(cur_phase),
                     test_err, test_chk);
        n_tests++;
        test_chk = 0;
        test_err = 0;
    endtask

    //************************************************************
    // burst format and data order
    //************************************************************
    task automatic check_output();
        if (flash_out.stb)
        begin
            if (burst_pos == 0)
            begin
                if (busy_d2)
                    complain("burst started although the idle writer saw busy high");
                if (model_q.size() < PAGE_BYTES)
                    complain("burst started before a whole page was waiting");
                compare("flash_out.data", int'(OP_PAGE_PROGRAM), int'(flash_out.data));
            end
            else if (burst_pos == 1)
                compare("flash_out.data", page_exp % 256, int'(flash_out.data));
            else if (model_q.size() == 0)
                complain("data byte sent while no accepted byte was waiting");
            else
                compare("flash_out.data", int'(model_q.pop_front()), int'(flash_out.data));
            compare("flash_out.last", int'(burst_pos == 5), int'(flash_out.last));
            if (burst_pos == 5)
            begin
                burst_pos = 0;
                page_exp++;                     // next burst carries the next index
            end
            else
                burst_pos++;
        end
        else
        begin
            compare("flash_out.last", 0, int'(flash_out.last));  // no last between bursts
            if (burst_pos != 0)
            begin
                complain("burst stopped before its sixth byte");
                burst_pos = 0;
            end
        end
    endtask

    // flags against the model occupancy
    task automatic check_flags();
        int cnt;
        cnt = model_q.size();
        compare("status.level", cnt, int'(status.level));
        compare("status.full", int'(cnt == FIFO_DEPTH), int'(status.full));
        compare("status.empty", int'(cnt == 0), int'(status.empty));
        compare("status.almost_full", int'(cnt >= ALMOST_FULL_NUM), int'(status.almost_full));
        compare("status.almost_empty", int'(cnt <= ALMOST_EMPTY_NUM),
                int'(status.almost_empty));
    endtask

    // outputs here still hold what the previous edge made
    always @(posedge rclk)
    begin
        if (rrst)
        begin
            model_q.delete();
            burst_pos = 0;
            page_exp  = 0;
            busy_d1   = 1'b0;
            busy_d2   = 1'b0;
        end
        else
        begin
            if (phase != cur_phase)
            begin
                finish_test();
                cur_phase = phase;
            end
            check_output();                     // pop of the last edge first
            check_flags();
            if (in_stb && !status.full)
                model_q.push_back(in_data);     // taken on this edge
            busy_d2 = busy_d1;
            busy_d1 = flash_busy;
        end
    end

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen
(
    output logic rclk,
    output logic rrst
);

    // 4 ns period
    initial
    begin
        rclk = 1'b0;
        forever #2 rclk = ~rclk;
    end

    // reset over three cycles, dropped on a falling edge
    initial
    begin
        rrst = 1'b1;
        repeat (3) @(negedge rclk);
        rrst = 1'b0;
    end

endmodule

// File: verification/tb_top.sv
`timescale 1ns/1ps

module tb_top
    import ru_pkg::*;
();

    logic                  rclk;
    logic                  rrst;
    logic                  in_stb;
    logic [DATA_WIDTH-1:0] in_data;
    logic                  flash_busy;
    fifo_status_t          status;
    flash_byte_t           flash_out;
    int                    phase;
    int                    check_cnt;
    int                    err_cnt;
    int                    test_cnt;

    tb_clk_gen u_clk_gen (
        .rclk (rclk),
        .rrst (rrst)
    );

    ru_write_channel uut (
        .rclk       (rclk),
        .rrst       (rrst),
        .in_stb     (in_stb),
        .in_data    (in_data),
        .flash_busy (flash_busy),
        .status     (status),
        .flash_out  (flash_out)
    );

    tb_checker u_checker (
        .rclk       (rclk),
        .rrst       (rrst),
        .phase      (phase),
        .in_stb     (in_stb),
        .in_data    (in_data),
        .flash_busy (flash_busy),
        .status     (status),
        .flash_out  (flash_out),
        .check_cnt  (check_cnt),
        .err_cnt    (err_cnt),
        .test_cnt   (test_cnt)
    );

    //************************************************************
    // stimulus helpers, all on the falling edge
    //************************************************************
    task automatic drive_push(input logic stb);
        in_stb  = stb;
        in_data = DATA_WIDTH'($urandom);
    endtask

    task automatic note_timeout(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
    endtask

    // rrst only moves on falling edges, so look at it on rising ones
    task automatic wait_reset_release(input int limit, output bit ok);
        int n;
        n = 0;
        @(posedge rclk);
        while (rrst && n < limit)
        begin
            @(posedge rclk);
            n++;
        end
        ok = !rrst;
    endtask

    // keeps pushing until the fifo reports full
    task automatic wait_full(input int limit, output bit ok);
        int n;
        n = 0;
        while (!status.full && n < limit)
        begin
            @(negedge rclk);
            drive_push(1'b1);
            n++;
        end
        ok = status.full;
    endtask

    // less than a page left and no strobe for a few cycles
    task automatic wait_drained(input int limit, output bit ok);
        int n;
        int quiet;
        n     = 0;
        quiet = 0;
        while (quiet < 4 && n < limit)
        begin
            @(negedge rclk);
            if (status.level < LEVEL_WIDTH'(PAGE_BYTES) && !flash_out.stb)
                quiet++;
            else
                quiet = 0;
            n++;
        end
        ok = (quiet >= 4);
    endtask

    //************************************************************
    // test sequence
    //************************************************************
    initial
    begin
        bit ok;
        in_stb     = 1'b0;
        in_data    = '0;
        flash_busy = 1'b0;
        phase      = 0;
        void'($urandom(32'h76e8));              // single seed for the run

        wait_reset_release(20, ok);
        if (!ok)
            note_timeout("reset release");
        else
            repeat (2) @(negedge rclk);         // flags right after reset

        // random pushes, programmer idle
        if (ok)
        begin
            phase = 1;
            repeat (240)
            begin
                @(negedge rclk);
                drive_push(1'($urandom_range(0, 1)));
            end
            @(negedge rclk);
            in_stb = 1'b0;
            wait_drained(200, ok);
            if (!ok)
                note_timeout("the fifo to drain after random pushes");
        end

        // programmer busy, host keeps pushing
        if (ok)
        begin
            phase      = 2;
            flash_busy = 1'b1;
            wait_full(64, ok);
            if (!ok)
                note_timeout("status.full under back-pressure");
            else
            begin
                repeat (8)
                begin
                    @(negedge rclk);
                    drive_push(1'b1);           // all dropped
                end
            end
        end

        // release and drain
        if (ok)
        begin
            @(negedge rclk);
            phase      = 3;
            flash_busy = 1'b0;
            in_stb     = 1'b0;
            wait_drained(200, ok);
            if (!ok)
                note_timeout("the fifo to drain after back-pressure");
        end

        phase  = 4;
        in_stb = 1'b0;
        repeat (2) @(negedge rclk);
        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (ok && err_cnt == 0 && check_cnt > 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
